/* cpu.f */
src/tsc_pkg.sv
src/stage_reg.sv
src/fetch_unit.sv
src/decode_unit.sv
src/register_file.sv
src/execute_unit.sv
src/retire_unit.sv
src/cpu.sv
tb/cpu_checker.sv
tb/cpu_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f cpu.f --top-module cpu_tb -o cpu_sim > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "verilator build failed"
	exit 1
fi
./obj_dir/cpu_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi
if grep -q "TEST FAILED" sim.log; then
	exit 1
fi
exit 0

/* src/cpu.sv */
`timescale 1ns/1ns

module cpu (
	input  logic           reset_n,
	input  logic           arst_n,
	output logic           read_m1,
	output tsc_pkg::word_t address1,
	input  tsc_pkg::word_t data1,
	output tsc_pkg::word_t output_port,
	output tsc_pkg::word_t num_inst,
	output logic           is_halted
);
	import tsc_pkg::*;

	if_id_t fetched, if_q;
	id_ex_t decoded, id_q;
	ex_wb_t executed, ex_q;
	logic if_valid, id_valid, ex_valid;
	reg_addr_t rs, rt;
	word_t rs_data, rt_data;
	reg_wr_t wr;
	logic redirect_valid;
	word_t redirect_target;
	logic halted;

	fetch_unit i_fetch (.reset_n, .arst_n, .redirect_valid, .redirect_target, .halted,
		.read_m1, .address1, .data1, .fetched);

	stage_reg #(.payload_t(if_id_t)) i_if_id (.reset_n, .arst_n, .flush(redirect_valid),
		.hold(halted), .d(fetched), .d_valid(read_m1), .q(if_q), .q_valid(if_valid));

	decode_unit i_decode (.fetched(if_q), .rs_data, .rt_data, .rs, .rt, .decoded);

	register_file i_regs (.reset_n, .arst_n, .rs, .rt, .rs_data, .rt_data, .wr);

	stage_reg #(.payload_t(id_ex_t)) i_id_ex (.reset_n, .arst_n, .flush(redirect_valid),
		.hold(halted), .d(decoded), .d_valid(if_valid), .q(id_q), .q_valid(id_valid));

	execute_unit i_execute (.stage(id_q), .stage_valid(id_valid), .wr, .redirect_valid,
		.redirect_target, .result(executed));

	stage_reg #(.payload_t(ex_wb_t)) i_ex_wb (.reset_n, .arst_n, .flush(1'b0),
		.hold(halted), .d(executed), .d_valid(id_valid), .q(ex_q), .q_valid(ex_valid));

	retire_unit i_retire (.reset_n, .arst_n, .stage(ex_q), .stage_valid(ex_valid), .wr,
		.output_port, .num_inst, .is_halted, .halted);

endmodule

/* src/decode_unit.sv */
`timescale 1ns/1ns

module decode_unit (
	input  tsc_pkg::if_id_t   fetched,
	input  tsc_pkg::word_t    rs_data,
	input  tsc_pkg::word_t    rt_data,
	output tsc_pkg::reg_addr_t rs,
	output tsc_pkg::reg_addr_t rt,
	output tsc_pkg::id_ex_t   decoded
);
	import tsc_pkg::*;

	opcode_t opcode;
	func_t func;
	reg_addr_t rd;
	reg_addr_t dest;
	logic [7:0] imm8;
	logic [11:0] target;
	ctrl_t ctrl;
	word_t imm;

	assign opcode = fetched.inst[15:12];
	assign rs     = fetched.inst[11:10];
	assign rt     = fetched.inst[9:8];
	assign rd     = fetched.inst[7:6];
	assign func   = fetched.inst[5:0];
	assign imm8   = fetched.inst[7:0];
	assign target = fetched.inst[11:0];

	always_comb begin
		ctrl = '0; // unknown codes fall out as no-ops
		dest = rt; // immediates write rt
		case (opcode)
			op_rtype: begin
				dest = rd;
				ctrl.reg_write = 1'b1;
				case (func)
					fn_add: ctrl.alu_op = alu_add;
					fn_sub: ctrl.alu_op = alu_sub;
					fn_and: ctrl.alu_op = alu_and;
					fn_orr: ctrl.alu_op = alu_orr;
					fn_not: ctrl.alu_op = alu_not;
					fn_tcp: ctrl.alu_op = alu_tcp;
					fn_shl: ctrl.alu_op = alu_shl;
					fn_shr: ctrl.alu_op = alu_shr;
					fn_wwd: begin
						ctrl.reg_write = 1'b0;
						ctrl.is_wwd = 1'b1;
					end
					fn_hlt: begin
						ctrl.reg_write = 1'b0;
						ctrl.is_hlt = 1'b1;
					end
					default: ctrl = '0;
				endcase
			end
			op_adi: ctrl = '{alu_op: alu_add, alu_src: 1'b1, reg_write: 1'b1, default: 1'b0};
			op_ori: ctrl = '{alu_op: alu_orr, alu_src: 1'b1, reg_write: 1'b1, default: 1'b0};
			op_lhi: ctrl = '{alu_op: alu_pass_b, alu_src: 1'b1, reg_write: 1'b1, default: 1'b0};
			op_jmp: ctrl.is_jmp = 1'b1;
			default: ctrl = '0;
		endcase
	end

	always_comb begin
		case (opcode)
			op_ori:  imm = {8'h00, imm8};
			op_lhi:  imm = {imm8, 8'h00};
			op_jmp:  imm = {fetched.pc[15:12], target}; // stays inside the current 4k page
			default: imm = {{8{imm8[7]}}, imm8};
		endcase
	end

	assign decoded = '{ctrl: ctrl, pc: fetched.pc, rs: rs, rt: rt, dest: dest,
		rs_data: rs_data, rt_data: rt_data, imm: imm};

endmodule

/* src/execute_unit.sv */
`timescale 1ns/1ns

module execute_unit (
	input  tsc_pkg::id_ex_t  stage,
	input  logic             stage_valid,
	input  tsc_pkg::reg_wr_t wr,
	output logic             redirect_valid,
	output tsc_pkg::word_t   redirect_target,
	output tsc_pkg::ex_wb_t  result
);
	import tsc_pkg::*;

	word_t a;
	word_t rt_val;
	word_t b;
	word_t y;

	// forward from write-back
	assign a      = (wr.en && wr.addr == stage.rs) ? wr.data : stage.rs_data;
	assign rt_val = (wr.en && wr.addr == stage.rt) ? wr.data : stage.rt_data;
	assign b      = stage.ctrl.alu_src ? stage.imm : rt_val;

	always_comb begin
		case (stage.ctrl.alu_op)
			alu_add:    y = a + b;
			alu_sub:    y = a - b;
			alu_and:    y = a & b;
			alu_orr:    y = a | b;
			alu_not:    y = ~a;
			alu_tcp:    y = ~a + 16'd1;
			alu_shl:    y = {a[14:0], 1'b0};
			alu_shr:    y = {a[15], a[15:1]}; // arithmetic
			alu_pass_b: y = b;
			default:    y = '0;
		endcase
	end

	assign redirect_valid  = stage_valid && stage.ctrl.is_jmp;
	assign redirect_target = stage.imm;

	assign result = '{ctrl: stage.ctrl, dest: stage.dest, result: y, rs_val: a};

endmodule

/* src/fetch_unit.sv */
`timescale 1ns/1ns

module fetch_unit (
	input  logic            reset_n,
	input  logic            arst_n,
	input  logic            redirect_valid,
	input  tsc_pkg::word_t  redirect_target,
	input  logic            halted,
	output logic            read_m1,
	output tsc_pkg::word_t  address1,
	input  tsc_pkg::word_t  data1,
	output tsc_pkg::if_id_t fetched
);
	import tsc_pkg::*;

	word_t pc;
	logic running; // set on the first edge out of reset

	always_ff @(posedge reset_n or negedge arst_n) begin
		if (!arst_n) begin
			pc <= '0;
			running <= 1'b0;
		end else begin
			running <= 1'b1;
			if (!halted) begin
				if (redirect_valid)
					pc <= redirect_target;
				else if (read_m1)
					pc <= pc + 16'd1;
			end
		end
	end

	assign read_m1  = running && !halted;
	assign address1 = pc;
	assign fetched  = '{pc: pc, inst: data1}; // memory answers in the same cycle

	a_pc_frozen: assert property (@(posedge reset_n) disable iff (!arst_n)
		halted |=> $stable(pc));

endmodule

/* src/register_file.sv */
`timescale 1ns/1ns

module register_file (
	input  logic               reset_n,
	input  logic               arst_n,
	input  tsc_pkg::reg_addr_t rs,
	input  tsc_pkg::reg_addr_t rt,
	output tsc_pkg::word_t     rs_data,
	output tsc_pkg::word_t     rt_data,
	input  tsc_pkg::reg_wr_t   wr
);
	import tsc_pkg::*;

	word_t regs [num_regs];

	always_ff @(posedge reset_n or negedge arst_n) begin
		if (!arst_n)
			regs <= '{default: '0};
		else if (wr.en)
			regs[wr.addr] <= wr.data;
	end

	// write-through so decode sees the value retiring this cycle
	assign rs_data = (wr.en && wr.addr == rs) ? wr.data : regs[rs];
	assign rt_data = (wr.en && wr.addr == rt) ? wr.data : regs[rt];

endmodule

/* src/retire_unit.sv */
`timescale 1ns/1ns

module retire_unit (
	input  logic             reset_n,
	input  logic             arst_n,
	input  tsc_pkg::ex_wb_t  stage,
	input  logic             stage_valid,
	output tsc_pkg::reg_wr_t wr,
	output tsc_pkg::word_t   output_port,
	output tsc_pkg::word_t   num_inst,
	output logic             is_halted,
	output logic             halted
);
	import tsc_pkg::*;

	logic halt_q;
	logic live; // a real instruction retires this cycle

	assign live = stage_valid && !halt_q;
	assign wr = '{en: live && stage.ctrl.reg_write, addr: stage.dest, data: stage.result};

	always_ff @(posedge reset_n or negedge arst_n) begin
		if (!arst_n) begin
			halt_q <= 1'b0;
			num_inst <= '0;
			output_port <= '0;
		end else if (live) begin
			num_inst <= num_inst + 16'd1; // HLT counts too
			if (stage.ctrl.is_wwd)
				output_port <= stage.rs_val;
			if (stage.ctrl.is_hlt)
				halt_q <= 1'b1;
		end
	end

	assign halted    = halt_q;
	assign is_halted = halt_q;

	a_count_frozen: assert property (@(posedge reset_n) disable iff (!arst_n)
		halt_q |=> $stable(num_inst));

endmodule

/* src/stage_reg.sv */
`timescale 1ns/1ns

module stage_reg #(
	parameter type payload_t = logic
) (
	input  logic     reset_n,
	input  logic     arst_n,
	input  logic     flush,
	input  logic     hold,
	input  payload_t d,
	input  logic     d_valid,
	output payload_t q,
	output logic     q_valid
);

	always_ff @(posedge reset_n or negedge arst_n) begin
		if (!arst_n)
			q_valid <= 1'b0;
		else if (flush) // flush wins over hold
			q_valid <= 1'b0;
		else if (!hold)
			q_valid <= d_valid;
	end

	always_ff @(posedge reset_n) begin
		if (!hold)
			q <= d;
	end

	a_flush_kills: assert property (@(posedge reset_n) disable iff (!arst_n)
		flush |=> !q_valid);

endmodule

/* src/tsc_pkg.sv */
package tsc_pkg;

	typedef logic [15:0] word_t;
	typedef logic [1:0]  reg_addr_t;
	typedef logic [3:0]  opcode_t;
	typedef logic [5:0]  func_t;

	localparam opcode_t op_rtype = 4'd15;
	localparam opcode_t op_adi   = 4'd4;
	localparam opcode_t op_ori   = 4'd5;
	localparam opcode_t op_lhi   = 4'd6;
	localparam opcode_t op_jmp   = 4'd9;

	localparam func_t fn_add = 6'd0;
	localparam func_t fn_sub = 6'd1;
	localparam func_t fn_and = 6'd2;
	localparam func_t fn_orr = 6'd3;
	localparam func_t fn_not = 6'd4;
	localparam func_t fn_tcp = 6'd5;
	localparam func_t fn_shl = 6'd6;
	localparam func_t fn_shr = 6'd7;
	localparam func_t fn_wwd = 6'd28;
	localparam func_t fn_hlt = 6'd29;

	localparam int num_regs = 4;

	typedef enum logic [3:0] {
		alu_add, alu_sub, alu_and, alu_orr,
		alu_not, alu_tcp, alu_shl, alu_shr,
		alu_pass_b // LHI, immediate straight through
	} alu_op_t;

	typedef struct packed {
		alu_op_t alu_op;
		logic    alu_src; // b operand from imm instead of rt
		logic    reg_write;
		logic    is_jmp;
		logic    is_wwd;
		logic    is_hlt;
	} ctrl_t;

	typedef struct packed {
		word_t pc;
		word_t inst;
	} if_id_t;

	typedef struct packed {
		ctrl_t     ctrl;
		word_t     pc;
		reg_addr_t rs;
		reg_addr_t rt;
		reg_addr_t dest;
		word_t     rs_data;
		word_t     rt_data;
		word_t     imm; // extended immediate or jump target
	} id_ex_t;

	typedef struct packed {
		ctrl_t     ctrl;
		reg_addr_t dest;
		word_t     result;
		word_t     rs_val; // forwarded rs, for WWD
	} ex_wb_t;

	typedef struct packed {
		logic      en;
		reg_addr_t addr;
		word_t     data;
	} reg_wr_t;

endpackage

/* tb/cpu_checker.sv */
`timescale 1ns/1ns

module cpu_checker #(
	parameter int prog_len = 48
) (
	input  logic           reset_n,
	input  logic           arst_n,
	input  logic           read_m1,
	input  tsc_pkg::word_t address1,
	input  tsc_pkg::word_t output_port,
	input  tsc_pkg::word_t num_inst,
	input  logic           is_halted,
	input  tsc_pkg::word_t prog [prog_len],
	output logic           done,
	output int             errors
);
	import tsc_pkg::*;

	word_t m_regs [num_regs];
	word_t m_pc, m_out, m_count;
	logic m_halted, m_after_jmp, m_wrote;
	reg_addr_t m_dest;
	int pass_cnt [8] = '{default: 0};
	int fail_cnt [8] = '{default: 0};
	int n_pass = 0;

	task automatic check_val(input string name, input word_t exp, input word_t act,
			input logic [2:0] test);
		if (act !== exp) begin
			$display("** Error %s: expected %h, got %h", name, exp, act);
			fail_cnt[test]++;
			errors++;
		end else begin
			pass_cnt[test]++;
			n_pass++;
		end
	endtask

	task automatic report_test(input logic [2:0] test, input string title);
		$display("test %0d %s: %0d checks, %0d errors", test, title,
			pass_cnt[test] + fail_cnt[test], fail_cnt[test]);
	endtask

	// one instruction of the ISA; test is the behavior its checks count toward
	task automatic step_model(output logic [2:0] test);
		word_t inst;
		word_t a;
		word_t b;
		word_t res;
		word_t nxt;
		logic wr;
		reg_addr_t dest;
		inst = (m_pc < 16'(prog_len)) ? prog[m_pc[5:0]] : '0;
		a = m_regs[inst[11:10]];
		b = m_regs[inst[9:8]];
		res = '0;
		nxt = m_pc + 16'd1;
		wr = 1'b1;
		dest = inst[9:8]; // immediates write rt
		test = 3'd2;
		case (inst[15:12])
			op_rtype: begin
				dest = inst[7:6];
				case (inst[5:0])
					fn_add: res = a + b;
					fn_sub: res = a - b;
					fn_and: res = a & b;
					fn_orr: res = a | b;
					fn_not: res = ~a;
					fn_tcp: res = 16'd0 - a;
					fn_shl: res = a << 1;
					fn_shr: res = $signed(a) >>> 1;
					default: wr = 1'b0;
				endcase
				if (inst[5:0] == fn_wwd) begin
					m_out = a;
					if (m_wrote && m_dest == inst[11:10])
						test = 3'd3;
				end
				if (inst[5:0] == fn_hlt)
					m_halted = 1'b1;
			end
			op_adi: res = a + {{8{inst[7]}}, inst[7:0]};
			op_ori: res = a | {8'h00, inst[7:0]};
			op_lhi: res = {inst[7:0], 8'h00};
			op_jmp: begin
				nxt = {m_pc[15:12], inst[11:0]};
				wr = 1'b0;
			end
			default: wr = 1'b0; // unknown opcode is a no-op
		endcase
		if (m_after_jmp || inst[15:12] == op_jmp)
			test = 3'd4;
		if (m_halted)
			test = 3'd5;
		if (wr)
			m_regs[dest] = res;
		m_after_jmp = (inst[15:12] == op_jmp);
		m_wrote = wr;
		m_dest = dest;
		m_pc = nxt;
		m_count = m_count + 16'd1;
	endtask

	initial begin
		logic [2:0] test;
		int gap;
		done = 1'b0;
		errors = 0;
		m_regs = '{default: '0};
		m_pc = '0;
		m_out = '0;
		m_count = '0;
		m_halted = 1'b0;
		m_after_jmp = 1'b0;
		m_wrote = 1'b0;
		m_dest = '0;
		wait (arst_n === 1'b1);
		@(posedge reset_n);
		@(negedge reset_n); // first fetch cycle
		check_val("num_inst", 16'd0, num_inst, 3'd1);
		check_val("output_port", 16'd0, output_port, 3'd1);
		check_val("is_halted", 16'd0, 16'(is_halted), 3'd1);
		check_val("read_m1", 16'd1, 16'(read_m1), 3'd1);
		check_val("address1", 16'd0, address1, 3'd1);
		report_test(3'd1, "reset state");
		gap = 4; // the first word retires at the end of its fourth cycle
		while (!m_halted) begin
			repeat (gap) @(negedge reset_n);
			step_model(test);
			check_val("num_inst", m_count, num_inst, test);
			check_val("output_port", m_out, output_port, test);
			check_val("is_halted", 16'(m_halted), 16'(is_halted), test);
			gap = m_after_jmp ? 3 : 1; // two bubbles behind a jump
		end
		report_test(3'd2, "alu and immediate results");
		report_test(3'd3, "dependent neighbors");
		report_test(3'd4, "jumps");
		repeat (10) begin
			@(negedge reset_n);
			check_val("num_inst", m_count, num_inst, 3'd5);
			check_val("output_port", m_out, output_port, 3'd5);
			check_val("is_halted", 16'd1, 16'(is_halted), 3'd5);
			check_val("read_m1", 16'd0, 16'(read_m1), 3'd5);
		end
		report_test(3'd5, "halt");
		$display("checks: %0d passed, %0d errors", n_pass, errors);
		done = 1'b1;
	end

endmodule

/* tb/cpu_tb.sv */
`timescale 1ns/1ns

module cpu_tb;
	import tsc_pkg::*;

	localparam int prog_len = 48;
	localparam int max_cycles = 4 * prog_len + 20;

	logic reset_n; // the clock, under the DUT's port name
	logic arst_n;
	logic read_m1;
	word_t address1;
	word_t data1 = '0;
	word_t output_port;
	word_t num_inst;
	logic is_halted;
	word_t prog [prog_len];
	int seed = 67282;
	logic chk_done;
	int chk_errors;

	cpu i_dut (.reset_n, .arst_n, .read_m1, .address1, .data1, .output_port, .num_inst,
		.is_halted);

	cpu_checker #(.prog_len(prog_len)) cpu_checker (.reset_n, .arst_n, .read_m1, .address1,
		.output_port, .num_inst, .is_halted, .prog, .done(chk_done), .errors(chk_errors));

	function automatic word_t wwd_word(input reg_addr_t rs);
		return {op_rtype, rs, 4'h0, fn_wwd};
	endfunction

	task automatic build_program();
		int i;
		int k;
		int since_wwd;
		int jumps;
		int skip;
		int kind;
		logic [31:0] r;
		reg_addr_t last_dest;
		reg_addr_t rs;
		i = 0;
		since_wwd = 0;
		jumps = 0;
		last_dest = '0;
		while (i < prog_len - 1) begin
			r = $random(seed);
			if (since_wwd == 3) begin
				prog[6'(i)] = wwd_word(last_dest); // reads back the newest result
				since_wwd = 0;
				i++;
			end else if (r[31:29] == 3'd0 && jumps < 4 && i + 4 < prog_len - 1) begin
				skip = 1 + int'(r[28:27]) % 3;
				prog[6'(i)] = {op_jmp, 12'(i + 1 + skip)}; // forward only
				for (k = 1; k <= skip; k++)
					prog[6'(i + k)] = wwd_word(r[26:25]); // shadow words, never retire
				i += skip + 1;
				jumps++;
			end else begin
				rs = r[0] ? last_dest : r[2:1]; // often chained on the last result
				last_dest = r[4:3];
				kind = int'(r[15:8]) % 11;
				if (kind < 8) // function codes 0 to 7 follow ALU order
					prog[6'(i)] = {op_rtype, rs, r[6:5], last_dest, 6'(kind)};
				else
					prog[6'(i)] = {kind == 8 ? op_adi : kind == 9 ? op_ori : op_lhi,
						rs, last_dest, r[23:16]};
				since_wwd++;
				i++;
			end
		end
		prog[6'(prog_len - 1)] = {op_rtype, 6'h00, fn_hlt};
	endtask

	initial begin
		reset_n = 1'b0;
		forever #2 reset_n = ~reset_n;
	end

	initial begin
		arst_n = 1'b0;
		build_program();
		repeat (4) @(negedge reset_n);
		arst_n <= 1'b1;
	end

	// instruction memory, answers the fetch address within the cycle
	always @(negedge reset_n)
		data1 <= (address1 < 16'(prog_len)) ? prog[address1[5:0]] : '0;

	initial begin : watchdog
		int cycles;
		cycles = 0;
		while (chk_done !== 1'b1 && cycles < max_cycles) begin
			@(posedge reset_n);
			cycles++;
		end
		if (chk_done !== 1'b1)
			$display("timeout: the processor did not halt within %0d cycles", max_cycles);
		if (chk_done === 1'b1 && chk_errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule
